// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  // data and address width
  localparam int XLEN = 32;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    // register forms
    op_add  = 4'h1,
    op_sub  = 4'h2,
    op_and  = 4'h3,
    op_or   = 4'h4,
    op_xor  = 4'h5,
    op_sll  = 4'h6,
    op_srl  = 4'h7,
    op_slt  = 4'h8,
    // immediate forms
    op_addi = 4'h9,
    op_lui  = 4'ha,
    // branches, offset in rd
    op_beq  = 4'hb,
    op_bne  = 4'hc,
    op_jal  = 4'hd
  } op_e;

  // register view of the operand word
  typedef struct packed {
    logic [XLEN-6:0] spare;
    reg_idx_t        rs2;
  } opnd_src_t;

  // second operand word, decoded by op
  // imm: addi operand, lui value, jal byte offset
  // src: rs2 for register forms and branch compares
  typedef union packed {
    logic [XLEN-1:0] imm;
    opnd_src_t       src;
  } opnd_u;

endpackage

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

  import isa_pkg::*;

  // one instruction into a lane
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    op_e             op;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    opnd_u           opnd;
  } issue_slot_t;

  // registered lane result
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            we;
    reg_idx_t        rd;
    logic [XLEN-1:0] wdata;
    logic            redirect;
    logic [XLEN-1:0] target;
  } lane_out_t;

  // retirement record at the top
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            we;
    reg_idx_t        rd;
    logic [XLEN-1:0] wdata;
  } retire_t;

  // chosen redirect of a pair
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                     aclk,
  input  logic                     rst,
  input  isa_pkg::reg_idx_t        raddr0,
  input  isa_pkg::reg_idx_t        raddr1,
  input  isa_pkg::reg_idx_t        raddr2,
  input  isa_pkg::reg_idx_t        raddr3,
  output logic [isa_pkg::XLEN-1:0] rdata0,
  output logic [isa_pkg::XLEN-1:0] rdata1,
  output logic [isa_pkg::XLEN-1:0] rdata2,
  output logic [isa_pkg::XLEN-1:0] rdata3,
  input  logic                     we0,
  input  logic                     we1,
  input  isa_pkg::reg_idx_t        waddr0,
  input  isa_pkg::reg_idx_t        waddr1,
  input  logic [isa_pkg::XLEN-1:0] wdata0,
  input  logic [isa_pkg::XLEN-1:0] wdata1
);
  import isa_pkg::*;

  logic [XLEN-1:0] regs [2**$bits(reg_idx_t)];

  // port 1 last, so it wins on the same address
  always_ff @(posedge aclk) begin
    if (rst) begin
      for (int i = 0; i < 2**$bits(reg_idx_t); i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && (waddr0 != '0)) begin
        regs[waddr0] <= wdata0;
      end
      if (we1 && (waddr1 != '0)) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

  // x0 reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
  assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

endmodule

// ==== hdl/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane (
  input  logic                     aclk,
  input  logic                     rst,
  input  pipe_pkg::issue_slot_t    slot,
  output isa_pkg::reg_idx_t        rs1_idx,
  output isa_pkg::reg_idx_t        rs2_idx,
  input  logic [isa_pkg::XLEN-1:0] rs1_data,
  input  logic [isa_pkg::XLEN-1:0] rs2_data,
  output pipe_pkg::lane_out_t      result
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic            reg_form;
  logic            is_branch;
  logic            writes_rd;
  logic            taken;
  logic [XLEN-1:0] opnd_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] br_offset;
  logic [XLEN-1:0] target;
  lane_out_t       result_d;

  assign rs1_idx = slot.rs1;
  assign rs2_idx = slot.opnd.src.rs2;

  assign reg_form  = slot.op inside {op_add, op_sub, op_and, op_or,
                                     op_xor, op_sll, op_srl, op_slt};
  assign is_branch = (slot.op == op_beq) || (slot.op == op_bne);
  assign writes_rd = reg_form || (slot.op inside {op_addi, op_lui, op_jal});

  // branches compare two registers, immediates take the imm view
  assign opnd_b = (reg_form || is_branch) ? rs2_data : slot.opnd.imm;

  always_comb begin
    case (slot.op)
      op_add:  alu_res = rs1_data + opnd_b;
      op_sub:  alu_res = rs1_data - opnd_b;
      op_and:  alu_res = rs1_data & opnd_b;
      op_or:   alu_res = rs1_data | opnd_b;
      op_xor:  alu_res = rs1_data ^ opnd_b;
      op_sll:  alu_res = rs1_data << opnd_b[4:0];
      op_srl:  alu_res = rs1_data >> opnd_b[4:0];
      op_slt:  alu_res = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(opnd_b)};
      op_addi: alu_res = rs1_data + opnd_b;
      op_lui:  alu_res = opnd_b;
      // link value
      op_jal:  alu_res = slot.pc + XLEN'(4);
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    case (slot.op)
      op_beq:  taken = (rs1_data == opnd_b);
      op_bne:  taken = (rs1_data != opnd_b);
      op_jal:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // branch offset sits in rd, in words
  assign br_offset = {{(XLEN-7){slot.rd[4]}}, slot.rd, 2'b00};
  assign target    = slot.pc + ((slot.op == op_jal) ? slot.opnd.imm : br_offset);

  always_comb begin
    result_d.valid    = slot.valid;
    result_d.pc       = slot.pc;
    result_d.we       = slot.valid && writes_rd && (slot.rd != '0);
    result_d.rd       = slot.rd;
    result_d.wdata    = alu_res;
    result_d.redirect = slot.valid && taken;
    result_d.target   = target;
  end

  always_ff @(posedge aclk) begin
    result <= result_d;
    if (rst) begin
      result.valid    <= 1'b0;
      result.we       <= 1'b0;
      result.redirect <= 1'b0;
    end
  end

endmodule

// ==== hdl/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit (
  input  logic                     aclk,
  input  logic                     rst,
  input  pipe_pkg::lane_out_t      lane0,
  input  pipe_pkg::lane_out_t      lane1,
  output logic                     we0,
  output logic                     we1,
  output isa_pkg::reg_idx_t        waddr0,
  output isa_pkg::reg_idx_t        waddr1,
  output logic [isa_pkg::XLEN-1:0] wdata0,
  output logic [isa_pkg::XLEN-1:0] wdata1,
  output pipe_pkg::retire_t        retire0,
  output pipe_pkg::retire_t        retire1,
  output pipe_pkg::redirect_t      redirect
);
  import pipe_pkg::*;

  logic      squash1;
  retire_t   retire0_d;
  retire_t   retire1_d;
  redirect_t redirect_d;

  // older lane redirecting kills the younger one
  assign squash1 = lane0.valid && lane0.redirect;

  assign we0    = lane0.valid && lane0.we;
  assign we1    = lane1.valid && lane1.we && !squash1;
  assign waddr0 = lane0.rd;
  assign waddr1 = lane1.rd;
  assign wdata0 = lane0.wdata;
  assign wdata1 = lane1.wdata;

  always_comb begin
    retire0_d.valid = lane0.valid;
    retire0_d.pc    = lane0.pc;
    retire0_d.we    = we0;
    retire0_d.rd    = lane0.rd;
    retire0_d.wdata = lane0.wdata;

    retire1_d.valid = lane1.valid && !squash1;
    retire1_d.pc    = lane1.pc;
    retire1_d.we    = we1;
    retire1_d.rd    = lane1.rd;
    retire1_d.wdata = lane1.wdata;

    // lane 0 first
    redirect_d.valid  = squash1 || (lane1.valid && lane1.redirect);
    redirect_d.target = squash1 ? lane0.target : lane1.target;
  end

  always_ff @(posedge aclk) begin
    retire0  <= retire0_d;
    retire1  <= retire1_d;
    redirect <= redirect_d;
    if (rst) begin
      retire0.valid  <= 1'b0;
      retire0.we     <= 1'b0;
      retire1.valid  <= 1'b0;
      retire1.we     <= 1'b0;
      redirect.valid <= 1'b0;
    end
  end

endmodule

// ==== hdl/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
  input  logic                  aclk,
  input  logic                  rst,
  input  pipe_pkg::issue_slot_t slot0,
  input  pipe_pkg::issue_slot_t slot1,
  output pipe_pkg::retire_t     retire0,
  output pipe_pkg::retire_t     retire1,
  output pipe_pkg::redirect_t   redirect
);
  import isa_pkg::*;
  import pipe_pkg::*;

  reg_idx_t        l0_rs1_idx;
  reg_idx_t        l0_rs2_idx;
  reg_idx_t        l1_rs1_idx;
  reg_idx_t        l1_rs2_idx;
  logic [XLEN-1:0] l0_rs1_data;
  logic [XLEN-1:0] l0_rs2_data;
  logic [XLEN-1:0] l1_rs1_data;
  logic [XLEN-1:0] l1_rs2_data;
  lane_out_t       lane0_out;
  lane_out_t       lane1_out;
  logic            rf_we0;
  logic            rf_we1;
  reg_idx_t        rf_waddr0;
  reg_idx_t        rf_waddr1;
  logic [XLEN-1:0] rf_wdata0;
  logic [XLEN-1:0] rf_wdata1;

  // read ports 0/1 for lane 0, 2/3 for lane 1
  reg_file rf_i (
    .aclk   (aclk),
    .rst    (rst),
    .raddr0 (l0_rs1_idx),
    .raddr1 (l0_rs2_idx),
    .raddr2 (l1_rs1_idx),
    .raddr3 (l1_rs2_idx),
    .rdata0 (l0_rs1_data),
    .rdata1 (l0_rs2_data),
    .rdata2 (l1_rs1_data),
    .rdata3 (l1_rs2_data),
    .we0    (rf_we0),
    .we1    (rf_we1),
    .waddr0 (rf_waddr0),
    .waddr1 (rf_waddr1),
    .wdata0 (rf_wdata0),
    .wdata1 (rf_wdata1)
  );

  exec_lane lane0_i (
    .aclk     (aclk),
    .rst      (rst),
    .slot     (slot0),
    .rs1_idx  (l0_rs1_idx),
    .rs2_idx  (l0_rs2_idx),
    .rs1_data (l0_rs1_data),
    .rs2_data (l0_rs2_data),
    .result   (lane0_out)
  );

  exec_lane lane1_i (
    .aclk     (aclk),
    .rst      (rst),
    .slot     (slot1),
    .rs1_idx  (l1_rs1_idx),
    .rs2_idx  (l1_rs2_idx),
    .rs1_data (l1_rs1_data),
    .rs2_data (l1_rs2_data),
    .result   (lane1_out)
  );

  commit_unit commit_i (
    .aclk     (aclk),
    .rst      (rst),
    .lane0    (lane0_out),
    .lane1    (lane1_out),
    .we0      (rf_we0),
    .we1      (rf_we1),
    .waddr0   (rf_waddr0),
    .waddr1   (rf_waddr1),
    .wdata0   (rf_wdata0),
    .wdata1   (rf_wdata1),
    .retire0  (retire0),
    .retire1  (retire1),
    .redirect (redirect)
  );

endmodule

// ==== test/exec_core_model.svh ====
`ifndef EXEC_CORE_MODEL_SVH
`define EXEC_CORE_MODEL_SVH

// one slot of a table row
typedef struct packed {
  op_e             op;
  reg_idx_t        rd;
  reg_idx_t        rs1;
  logic [XLEN-1:0] opnd;
} stim_t;

localparam logic [XLEN-1:0] pc_base = 32'h0000_1000;

stim_t           tab0[$];
stim_t           tab1[$];
logic            tab_redir[$];
retire_t         exp_ret0[$];
retire_t         exp_ret1[$];
redirect_t       exp_red[$];
logic [15:0]     lfsr_state;
logic [XLEN-1:0] mregs [32];

// galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

task automatic draw_word(output logic [XLEN-1:0] w);
  for (int i = 0; i < XLEN; i++) begin
    w[i] = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  end
endtask

// rnd bit set replaces that slot's operand with an lfsr word
task automatic add_row(
  input op_e op0, input reg_idx_t rd0, input reg_idx_t rs10, input logic [XLEN-1:0] opnd0,
  input op_e op1, input reg_idx_t rd1, input reg_idx_t rs11, input logic [XLEN-1:0] opnd1,
  input logic [1:0] rnd, input logic redir
);
  stim_t s0;
  stim_t s1;
  s0 = {op0, rd0, rs10, opnd0};
  s1 = {op1, rd1, rs11, opnd1};
  if (rnd[0]) draw_word(s0.opnd);
  if (rnd[1]) draw_word(s1.opnd);
  tab0.push_back(s0);
  tab1.push_back(s1);
  tab_redir.push_back(redir);
endtask

// lane 0 | lane 1 | random mask | redirect expected
task automatic load_table();
  lfsr_state = 16'd59287;
  add_row(op_nop, 5'd0, 5'd0, 32'd0, op_nop, 5'd0, 5'd0, 32'd0, 2'b00, 1'b0);
  add_row(op_nop, 5'd0, 5'd0, 32'd0, op_nop, 5'd0, 5'd0, 32'd0, 2'b00, 1'b0);
  add_row(op_lui, 5'd1, 5'd0, 32'd0, op_lui, 5'd2, 5'd0, 32'd0, 2'b11, 1'b0);
  add_row(op_addi, 5'd3, 5'd0, 32'd0, op_addi, 5'd4, 5'd0, 32'd0, 2'b11, 1'b0);
  add_row(op_addi, 5'd5, 5'd1, 32'd0, op_lui, 5'd6, 5'd0, 32'd0, 2'b11, 1'b0);
  add_row(op_add, 5'd7, 5'd1, 32'd2, op_sub, 5'd8, 5'd1, 32'd2, 2'b00, 1'b0);
  add_row(op_sub, 5'd9, 5'd3, 32'd4, op_add, 5'd10, 5'd3, 32'd4, 2'b00, 1'b0);
  add_row(op_and, 5'd11, 5'd5, 32'd6, op_or, 5'd12, 5'd5, 32'd6, 2'b00, 1'b0);
  add_row(op_or, 5'd13, 5'd1, 32'd3, op_and, 5'd14, 5'd2, 32'd4, 2'b00, 1'b0);
  add_row(op_xor, 5'd15, 5'd7, 32'd8, op_sll, 5'd16, 5'd1, 32'd3, 2'b00, 1'b0);
  add_row(op_sll, 5'd17, 5'd2, 32'd4, op_xor, 5'd18, 5'd9, 32'd10, 2'b00, 1'b0);
  add_row(op_srl, 5'd19, 5'd1, 32'd5, op_slt, 5'd20, 5'd1, 32'd2, 2'b00, 1'b0);
  add_row(op_slt, 5'd21, 5'd3, 32'd4, op_srl, 5'd22, 5'd2, 32'd6, 2'b00, 1'b0);
  // x0 target, must stay zero
  add_row(op_addi, 5'd0, 5'd1, 32'd0, op_addi, 5'd23, 5'd11, 32'd0, 2'b11, 1'b0);
  // same rd on both lanes, then reads one and two rows later
  add_row(op_addi, 5'd24, 5'd0, 32'd0, op_addi, 5'd24, 5'd0, 32'd0, 2'b11, 1'b0);
  add_row(op_add, 5'd25, 5'd24, 32'd0, op_add, 5'd26, 5'd0, 32'd0, 2'b00, 1'b0);
  add_row(op_add, 5'd27, 5'd24, 32'd0, op_or, 5'd28, 5'd24, 32'd0, 2'b00, 1'b0);
  // branches and jumps
  add_row(op_beq, 5'd5, 5'd1, 32'd1, op_addi, 5'd29, 5'd0, 32'd0, 2'b10, 1'b1);
  add_row(op_jal, 5'd30, 5'd0, 32'h40, op_addi, 5'd31, 5'd0, 32'd0, 2'b10, 1'b1);
  add_row(op_nop, 5'd0, 5'd0, 32'd0, op_bne, 5'h1d, 5'd1, 32'd2, 2'b00, 1'b1);
  add_row(op_addi, 5'd29, 5'd0, 32'd0, op_bne, 5'd7, 5'd3, 32'd3, 2'b01, 1'b0);
  add_row(op_beq, 5'd2, 5'd1, 32'd2, op_jal, 5'd31, 5'd0, 32'hffff_fff0, 2'b00, 1'b1);
  add_row(op_nop, 5'd0, 5'd0, 32'd0, op_nop, 5'd0, 5'd0, 32'd0, 2'b00, 1'b0);
endtask

function automatic logic [XLEN-1:0] pc_of(input int r, input int lane);
  return pc_base + XLEN'(8 * r + 4 * lane);
endfunction

task automatic model_slot(
  input stim_t s, input logic [XLEN-1:0] pc,
  output retire_t ret, output logic red, output logic [XLEN-1:0] tgt
);
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] off;
  logic [XLEN-1:0] res;
  logic            v;
  a   = mregs[s.rs1];
  b   = mregs[s.opnd[4:0]];
  off = {{27{s.rd[4]}}, s.rd} << 2;
  v   = (s.op != op_nop);
  case (s.op)
    op_add:  res = a + b;
    op_sub:  res = a - b;
    op_and:  res = a & b;
    op_or:   res = a | b;
    op_xor:  res = a ^ b;
    op_sll:  res = a << b[4:0];
    op_srl:  res = a >> b[4:0];
    op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    op_addi: res = a + s.opnd;
    op_lui:  res = s.opnd;
    op_jal:  res = pc + 32'd4;
    default: res = '0;
  endcase
  ret.valid = v;
  ret.pc    = pc;
  ret.we    = v && !(s.op inside {op_beq, op_bne}) && (s.rd != 5'd0);
  ret.rd    = s.rd;
  ret.wdata = res;
  red = v && ((s.op == op_jal) || ((s.op == op_beq) && (a == b))
        || ((s.op == op_bne) && (a != b)));
  tgt = (s.op == op_jal) ? (pc + s.opnd) : (pc + off);
endtask

task automatic apply_write(input retire_t x);
  if (x.we && (x.rd != 5'd0)) mregs[x.rd] = x.wdata;
endtask

// writes of row r-2 become visible to row r
task automatic run_model();
  retire_t         r0;
  retire_t         r1;
  redirect_t       rdr;
  logic            red0;
  logic            red1;
  logic [XLEN-1:0] t0;
  logic [XLEN-1:0] t1;
  for (int i = 0; i < 32; i++) mregs[i] = '0;
  for (int r = 0; r < tab0.size(); r++) begin
    if (r >= 2) begin
      apply_write(exp_ret0[r-2]);
      apply_write(exp_ret1[r-2]);
    end
    model_slot(tab0[r], pc_of(r, 0), r0, red0, t0);
    model_slot(tab1[r], pc_of(r, 1), r1, red1, t1);
    if (red0) begin
      r1.valid = 1'b0;
      r1.we    = 1'b0;
    end
    rdr.valid  = red0 || red1;
    rdr.target = red0 ? t0 : t1;
    exp_ret0.push_back(r0);
    exp_ret1.push_back(r1);
    exp_red.push_back(rdr);
  end
endtask

`endif

// ==== test/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  logic        aclk;
  logic        rst;
  issue_slot_t slot0;
  issue_slot_t slot1;
  retire_t     retire0;
  retire_t     retire1;
  redirect_t   redirect;
  logic        table_ready;

  `include "exec_core_model.svh"

  exec_core exec_core_i (
    .aclk     (aclk),
    .rst      (rst),
    .slot0    (slot0),
    .slot1    (slot1),
    .retire0  (retire0),
    .retire1  (retire1),
    .redirect (redirect)
  );

  always #20 aclk = ~aclk;

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_retire(input string tag, input retire_t exp, input retire_t act);
    check_value({tag, ".valid"}, exp.valid, act.valid);
    check_value({tag, ".we"}, exp.we, act.we);
    if (exp.valid) begin
      check_value({tag, ".pc"}, exp.pc, act.pc);
    end
    if (exp.we) begin
      check_value({tag, ".rd"}, exp.rd, act.rd);
      check_value({tag, ".wdata"}, exp.wdata, act.wdata);
    end
  endtask

  // negative rows stand for the idle cycles right after reset
  task automatic check_row(input int r);
    retire_t idle;
    string   tag;
    idle = '0;
    tag  = $sformatf("row %0d", r);
    if (r < 0) begin
      check_retire({tag, " retire0"}, idle, retire0);
      check_retire({tag, " retire1"}, idle, retire1);
      check_value({tag, " redirect.valid"}, 1'b0, redirect.valid);
    end else begin
      check_retire({tag, " retire0"}, exp_ret0[r], retire0);
      check_retire({tag, " retire1"}, exp_ret1[r], retire1);
      check_value({tag, " model redirect.valid"}, tab_redir[r], exp_red[r].valid);
      check_value({tag, " redirect.valid"}, tab_redir[r], redirect.valid);
      if (tab_redir[r]) begin
        check_value({tag, " redirect.target"}, exp_red[r].target, redirect.target);
      end
    end
  endtask

  function automatic issue_slot_t make_slot(input stim_t s, input logic [XLEN-1:0] pc);
    issue_slot_t t;
    t.valid    = (s.op != op_nop);
    t.pc       = pc;
    t.op       = s.op;
    t.rd       = s.rd;
    t.rs1      = s.rs1;
    t.opnd.imm = s.opnd;
    return t;
  endfunction

  initial begin
    aclk        = 1'b0;
    rst         = 1'b1;
    slot0       = '0;
    slot1       = '0;
    table_ready = 1'b0;
    load_table();
    run_model();
    table_ready = 1'b1;
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    rst = 1'b0;
    // a row's retire shows up two falling edges after it was driven
    for (int j = 0; j < tab0.size() + 2; j++) begin
      if (j > 0) @(negedge aclk);
      check_row(j - 2);
      if (j < tab0.size()) begin
        slot0 = make_slot(tab0[j], pc_of(j, 0));
        slot1 = make_slot(tab1[j], pc_of(j, 1));
      end else begin
        slot0 = '0;
        slot1 = '0;
      end
    end
    $display("TEST OK");
    $finish;
  end

  // rows plus reset plus some slack
  initial begin
    wait (table_ready === 1'b1);
    #((tab0.size() + 16 + 10) * 40);
    $display("timeout: the run did not finish all rows in the allowed time");
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

// ==== filelist.f ====
+incdir+test
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/exec_lane.sv
hdl/commit_unit.sv
hdl/exec_core.sv
test/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - hdl/isa_pkg.sv
  - hdl/pipe_pkg.sv
  - hdl/reg_file.sv
  - hdl/exec_lane.sv
  - hdl/commit_unit.sv
  - hdl/exec_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/exec_core_tb.sv
